// ==== design/pac_pkg.sv ====
// Fixed 640x480 timing and a 28x36 maze of 8 px tiles; APB words are decoded by address only
package pac_pkg;

  // ------------------------------------------------------------------
  // VGA 640x480 timing
  localparam int h_vis  = 640;
  localparam int h_fp   = 16;
  localparam int h_sync = 96;
  localparam int h_tot  = 800;
  localparam int v_vis  = 480;
  localparam int v_fp   = 10;
  localparam int v_sync = 2;
  localparam int v_tot  = 525;
  localparam int coord_w = 10;                  // Pixel counter width

  // ------------------------------------------------------------------
  // Maze window and tile grid
  localparam int img_x0 = 208;                  // Centred horizontally
  localparam int img_y0 = 96;
  localparam int img_w  = 224;
  localparam int img_h  = 288;
  localparam int tile_shift = 3;                // 8x8 tiles
  localparam int tiles_x    = 28;
  localparam int tiles_y    = 36;
  localparam int tile_count = tiles_x * tiles_y;

  // Pac-Man movement
  localparam int hit_r     = 6;                 // 13x13 box
  localparam int speed_num = 125;               // 125/99 px per frame
  localparam int speed_den = 99;
  localparam int start_x   = 116;               // Centre of tile (14,28)
  localparam int start_y   = 228;

  localparam logic [1:0] dir_right = 2'd0;
  localparam logic [1:0] dir_left  = 2'd1;
  localparam logic [1:0] dir_up    = 2'd2;
  localparam logic [1:0] dir_down  = 2'd3;
  localparam logic [1:0] start_dir = dir_left;

  // Register word addresses
  localparam logic [9:0] ctrl_addr   = 10'd1023;  // Byte 0xFFC
  localparam logic [9:0] status_addr = 10'd1022;  // Byte 0xFF8

  localparam logic [3:0] col_black = 4'd0;
  localparam logic [3:0] col_dot   = 4'd6;
  localparam logic [3:0] col_pac   = 4'd11;
  localparam logic [3:0] col_wall  = 4'd12;

  // One APB word, three views picked by address
  typedef union packed {
    struct packed {
      logic [29:0] rsvd;
      logic        wall;
      logic        dot;
    } tile;
    struct packed {
      logic [29:0] rsvd;
      logic [1:0]  dir;
    } ctrl;
    struct packed {
      logic [6:0] rsvd_hi;
      logic [8:0] y;
      logic [6:0] rsvd_lo;
      logic [8:0] x;
    } status;
  } apb_word_t;

  // Row-major tile index from maze-local pixel coordinates
  function automatic logic [9:0] tile_index(input logic [8:0] lx, input logic [8:0] ly);
    return 10'(ly[8:tile_shift]) * 10'(tiles_x) + 10'(lx[7:tile_shift]);
  endfunction

  function automatic logic [11:0] palette(input logic [3:0] idx);
    case (idx)
      4'h0: return 12'h000;  // Black
      4'h1: return 12'h800;
      4'h2: return 12'h080;
      4'h3: return 12'hFA0;  // Orange
      4'h4: return 12'h008;
      4'h5: return 12'h808;
      4'h6: return 12'h941;  // Brown dot
      4'h7: return 12'hF00;
      4'h8: return 12'h888;
      4'h9: return 12'hF8F;  // Pink
      4'hA: return 12'h0F0;
      4'hB: return 12'hFF0;  // Yellow Pac-Man
      4'hC: return 12'h00F;  // Wall blue
      4'hD: return 12'hF0F;
      4'hE: return 12'h0FF;
      default: return 12'hFFF;
    endcase
  endfunction

endpackage

// ==== design/vga_timing.sv ====
// Free-running 640x480 counters; one pclk per pixel, sync pulses are active low
`timescale 1ns/1ps
module vga_timing (
  input  logic                        pclk,
  input  logic                        rst_n,
  output logic [pac_pkg::coord_w-1:0] hc,
  output logic [pac_pkg::coord_w-1:0] vc,
  output logic                        hs_raw,
  output logic                        vs_raw,
  output logic                        frame_tick
);
  localparam logic [9:0] h_last  = 10'(pac_pkg::h_tot - 1);
  localparam logic [9:0] v_last  = 10'(pac_pkg::v_tot - 1);
  localparam logic [9:0] hs_beg  = 10'(pac_pkg::h_vis + pac_pkg::h_fp);
  localparam logic [9:0] hs_end  = 10'(pac_pkg::h_vis + pac_pkg::h_fp + pac_pkg::h_sync);
  localparam logic [9:0] vs_beg  = 10'(pac_pkg::v_vis + pac_pkg::v_fp);
  localparam logic [9:0] vs_end  = 10'(pac_pkg::v_vis + pac_pkg::v_fp + pac_pkg::v_sync);

  // ------------------------------------------------------------------
  // Counters, vc steps when hc wraps
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      hc <= '0;
      vc <= '0;
    end else if (hc == h_last) begin
      hc <= '0;
      vc <= (vc == v_last) ? '0 : vc + 10'd1;
    end else begin
      hc <= hc + 10'd1;
    end
  end

  assign hs_raw = !((hc >= hs_beg) && (hc < hs_end));  // Low during 656..751
  assign vs_raw = !((vc >= vs_beg) && (vc < vs_end));  // Low during 490..491

  // Frame start, top left pixel
  assign frame_tick = (hc == '0) && (vc == '0);

endmodule

// ==== design/maze_apb_regs.sv ====
// APB slave with no wait states; words 1008..1021 and status writes answer with pslverr
`timescale 1ns/1ps
module maze_apb_regs (
  input  logic               pclk,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [11:0]        paddr,
  input  logic [31:0]        pwdata,
  output pac_pkg::apb_word_t prdata,
  output logic               pready,
  output logic               pslverr,
  input  logic [9:0]         tile_a,
  input  logic [9:0]         tile_b,
  input  logic [9:0]         render_tile,
  input  logic [8:0]         pac_x,
  input  logic [8:0]         pac_y,
  output logic               wall_a,
  output logic               wall_b,
  output logic               cell_wall,
  output logic               cell_dot,
  output logic [1:0]         pac_dir
);
  logic [1:0]         cells [pac_pkg::tile_count];  // {wall, dot}
  logic [9:0]         word;
  logic               is_tile;
  logic               is_ctrl;
  logic               is_status;
  logic               access;
  logic               bad;
  pac_pkg::apb_word_t wword;
  logic [1:0]         cell_ra;
  logic [1:0]         cell_rb;
  logic [1:0]         cell_rr;

  // Out-of-map indexes read as empty
  function automatic logic [1:0] cell_at(input logic [9:0] idx);
    return (idx < 10'(pac_pkg::tile_count)) ? cells[idx] : 2'b00;
  endfunction

  // ------------------------------------------------------------------
  // Address decode
  assign word      = paddr[11:2];                  // Word address
  assign wword     = pwdata;
  assign is_tile   = word < 10'(pac_pkg::tile_count);
  assign is_ctrl   = word == pac_pkg::ctrl_addr;
  assign is_status = word == pac_pkg::status_addr;
  assign access    = psel && penable;              // Access phase
  assign bad       = !is_tile && !is_ctrl && !(is_status && !pwrite);
  assign pslverr   = access && bad;
  assign pready    = 1'b1;                         // Never stalls

  // Writes land on the edge that closes the access phase
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      pac_dir <= pac_pkg::start_dir;
      for (int i = 0; i < pac_pkg::tile_count; i++) begin
        cells[i] <= 2'b00;
      end
    end else if (access && pwrite && !bad) begin
      if (is_tile) begin
        cells[word] <= {wword.tile.wall, wword.tile.dot};
      end
      if (is_ctrl) begin
        pac_dir <= wword.ctrl.dir;
      end
    end
  end

  // Read data, reserved fields stay zero
  always_comb begin
    prdata = '0;
    if (is_tile) begin
      prdata.tile.wall = cells[word][1];
      prdata.tile.dot  = cells[word][0];
    end else if (is_ctrl) begin
      prdata.ctrl.dir = pac_dir;
    end else if (is_status) begin
      prdata.status.x = pac_x;                     // Live position
      prdata.status.y = pac_y;
    end
  end

  // ------------------------------------------------------------------
  // Combinational read ports for motion and render
  assign cell_ra   = cell_at(tile_a);
  assign cell_rb   = cell_at(tile_b);
  assign cell_rr   = cell_at(render_tile);
  assign wall_a    = cell_ra[1];
  assign wall_b    = cell_rb[1];
  assign cell_wall = cell_rr[1];
  assign cell_dot  = cell_rr[0];

endmodule

// ==== design/pac_motion.sv ====
// Moves once per frame_tick at 125/99 px per frame; off-grid check points count as walls
`timescale 1ns/1ps
module pac_motion (
  input  logic       pclk,
  input  logic       rst_n,
  input  logic       frame_tick,
  input  logic [1:0] pac_dir,
  input  logic       wall_a,
  input  logic       wall_b,
  output logic [9:0] tile_a,
  output logic [9:0] tile_b,
  output logic [8:0] pac_x,
  output logic [8:0] pac_y
);
  localparam logic signed [10:0] radius = 11'(pac_pkg::hit_r);
  localparam logic signed [10:0] max_x  = 11'(pac_pkg::img_w);
  localparam logic signed [10:0] max_y  = 11'(pac_pkg::img_h);
  localparam logic [7:0]         two_den = 8'(2 * pac_pkg::speed_den);

  logic [6:0]         rem;                 // Remainder modulo 99
  logic [7:0]         sum;
  logic [6:0]         rem_next;
  logic [1:0]         step;
  logic signed [10:0] cx;
  logic signed [10:0] cy;
  logic signed [10:0] ahead;
  logic signed [10:0] ax;
  logic signed [10:0] ay;
  logic signed [10:0] bx;
  logic signed [10:0] by;
  logic               blocked;

  function automatic logic off_grid(input logic signed [10:0] x, input logic signed [10:0] y);
    return (x < 0) || (x >= max_x) || (y < 0) || (y >= max_y);
  endfunction

  // ------------------------------------------------------------------
  // Fractional speed, sum never reaches 3*99
  assign sum = {1'b0, rem} + 8'(pac_pkg::speed_num);

  always_comb begin
    if (sum >= two_den) begin
      step     = 2'd2;
      rem_next = 7'(sum - two_den);
    end else begin
      step     = 2'd1;                     // Sum is always >= 99
      rem_next = 7'(sum - 8'(pac_pkg::speed_den));
    end
  end

  // ------------------------------------------------------------------
  // Front-edge check points
  assign cx    = {2'b00, pac_x};
  assign cy    = {2'b00, pac_y};
  assign ahead = radius + {9'd0, step};   // Leading edge after the move

  always_comb begin
    ax = cx - radius;                      // Up/down spread across x
    bx = cx + radius;
    ay = cy;
    by = cy;
    case (pac_dir)
      pac_pkg::dir_right: begin
        ax = cx + ahead;
        bx = cx + ahead;
        ay = cy - radius;
        by = cy + radius;
      end
      pac_pkg::dir_left: begin
        ax = cx - ahead;
        bx = cx - ahead;
        ay = cy - radius;
        by = cy + radius;
      end
      pac_pkg::dir_up: begin
        ay = cy - ahead;
        by = cy - ahead;
      end
      default: begin                       // Down
        ay = cy + ahead;
        by = cy + ahead;
      end
    endcase
  end

  assign tile_a  = pac_pkg::tile_index(ax[8:0], ay[8:0]);
  assign tile_b  = pac_pkg::tile_index(bx[8:0], by[8:0]);
  assign blocked = off_grid(ax, ay) || wall_a || off_grid(bx, by) || wall_b;

  // Position update, visible the cycle after the tick
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      rem   <= '0;
      pac_x <= 9'(pac_pkg::start_x);
      pac_y <= 9'(pac_pkg::start_y);
    end else if (frame_tick) begin
      rem <= rem_next;
      if (!blocked) begin
        case (pac_dir)
          pac_pkg::dir_right: pac_x <= pac_x + 9'(step);
          pac_pkg::dir_left:  pac_x <= pac_x - 9'(step);
          pac_pkg::dir_up:    pac_y <= pac_y - 9'(step);
          default:            pac_y <= pac_y + 9'(step);
        endcase
      end
    end
  end

endmodule

// ==== design/pixel_render.sv ====
// One register stage from counters to pins; tile bits arrive combinationally for render_tile
`timescale 1ns/1ps
module pixel_render (
  input  logic                        pclk,
  input  logic                        rst_n,
  input  logic [pac_pkg::coord_w-1:0] hc,
  input  logic [pac_pkg::coord_w-1:0] vc,
  input  logic                        hs_raw,
  input  logic                        vs_raw,
  input  logic [8:0]                  pac_x,
  input  logic [8:0]                  pac_y,
  input  logic                        cell_wall,
  input  logic                        cell_dot,
  output logic [9:0]                  render_tile,
  output logic [pac_pkg::coord_w-1:0] h,
  output logic [pac_pkg::coord_w-1:0] v,
  output logic                        hs,
  output logic                        vs,
  output logic [3:0]                  r,
  output logic [3:0]                  g,
  output logic [3:0]                  b
);
  localparam logic signed [10:0] radius = 11'(pac_pkg::hit_r);
  localparam logic [9:0] x0 = 10'(pac_pkg::img_x0);
  localparam logic [9:0] y0 = 10'(pac_pkg::img_y0);

  logic               in_win;
  logic               vis;
  logic [8:0]         lx;
  logic [8:0]         ly;
  logic signed [10:0] ddx;
  logic signed [10:0] ddy;
  logic               in_pac;
  logic               in_dot;
  logic [3:0]         idx;
  logic [11:0]        rgb;

  // ------------------------------------------------------------------
  // Window and tile mapping
  assign in_win = (hc >= x0) && (hc < x0 + 10'(pac_pkg::img_w)) &&
                  (vc >= y0) && (vc < y0 + 10'(pac_pkg::img_h));
  assign vis    = (hc < 10'(pac_pkg::h_vis)) && (vc < 10'(pac_pkg::v_vis));
  assign lx     = 9'(hc - x0);             // Valid only inside the window
  assign ly     = 9'(vc - y0);
  assign render_tile = in_win ? pac_pkg::tile_index(lx, ly) : 10'd0;

  // Pac-Man box, centre +/- hit_r
  assign ddx    = $signed({2'b00, lx}) - $signed({2'b00, pac_x});
  assign ddy    = $signed({2'b00, ly}) - $signed({2'b00, pac_y});
  assign in_pac = (ddx >= -radius) && (ddx <= radius) && (ddy >= -radius) && (ddy <= radius);

  // 2x2 dot in the tile centre
  assign in_dot = cell_dot && (lx[2:0] == 3'd3 || lx[2:0] == 3'd4) &&
                  (ly[2:0] == 3'd3 || ly[2:0] == 3'd4);

  // Layer priority
  always_comb begin
    if (!in_win) begin
      idx = pac_pkg::col_black;
    end else if (in_pac) begin
      idx = pac_pkg::col_pac;
    end else if (in_dot) begin
      idx = pac_pkg::col_dot;
    end else if (cell_wall) begin
      idx = pac_pkg::col_wall;
    end else begin
      idx = pac_pkg::col_black;
    end
  end

  assign rgb = pac_pkg::palette(idx);

  // ------------------------------------------------------------------
  // Output register, syncs idle high
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      h         <= '0;
      v         <= '0;
      hs        <= 1'b1;
      vs        <= 1'b1;
      {r, g, b} <= 12'h000;
    end else begin
      h         <= hc;
      v         <= vc;
      hs        <= hs_raw;
      vs        <= vs_raw;
      {r, g, b} <= vis ? rgb : 12'h000;  // Blank in porches and sync
    end
  end

endmodule

// ==== design/pacman_top.sv ====
// Maze display core; the tile map and direction come only from APB, pready is tied high
`timescale 1ns/1ps
module pacman_top (
  input  logic                        pclk,
  input  logic                        rst_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [11:0]                 paddr,
  input  logic [31:0]                 pwdata,
  output pac_pkg::apb_word_t          prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic [pac_pkg::coord_w-1:0] h,
  output logic [pac_pkg::coord_w-1:0] v,
  output logic                        hs,
  output logic                        vs,
  output logic [3:0]                  r,
  output logic [3:0]                  g,
  output logic [3:0]                  b
);
  logic [pac_pkg::coord_w-1:0] hc;
  logic [pac_pkg::coord_w-1:0] vc;
  logic       hs_raw;
  logic       vs_raw;
  logic       frame_tick;
  logic [9:0] tile_a;
  logic [9:0] tile_b;
  logic [9:0] render_tile;
  logic       wall_a;
  logic       wall_b;
  logic       cell_wall;
  logic       cell_dot;
  logic [1:0] pac_dir;
  logic [8:0] pac_x;
  logic [8:0] pac_y;

  vga_timing u_timing (.pclk, .rst_n, .hc, .vc, .hs_raw, .vs_raw, .frame_tick);

  maze_apb_regs u_regs (
    .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .tile_a, .tile_b, .render_tile, .pac_x, .pac_y,
    .wall_a, .wall_b, .cell_wall, .cell_dot, .pac_dir
  );

  pac_motion u_motion (
    .pclk, .rst_n, .frame_tick, .pac_dir, .wall_a, .wall_b,
    .tile_a, .tile_b, .pac_x, .pac_y
  );

  pixel_render u_render (
    .pclk, .rst_n, .hc, .vc, .hs_raw, .vs_raw, .pac_x, .pac_y,
    .cell_wall, .cell_dot, .render_tile, .h, .v, .hs, .vs, .r, .g, .b
  );

endmodule

// ==== test/tb_pacman.sv ====
// APB traffic only in vertical blanking; one run of about eight frames from a fixed seed
`timescale 1ns/1ps
module tb_pacman;

  typedef logic [pac_pkg::coord_w-1:0] coord_t;

  localparam int tile_px     = 1 << pac_pkg::tile_shift;
  localparam int frame_len   = pac_pkg::h_tot * pac_pkg::v_tot;
  localparam int cycle_limit = 8 * frame_len + 10000;  // Eight frames plus slack
  localparam int hs_first    = pac_pkg::h_vis + pac_pkg::h_fp;
  localparam int hs_last     = hs_first + pac_pkg::h_sync - 1;
  localparam int vs_first    = pac_pkg::v_vis + pac_pkg::v_fp;
  localparam int vs_last     = vs_first + pac_pkg::v_sync - 1;
  localparam int tile_reads  = 40;

  // Reference colours for the four layers
  localparam logic [11:0] rgb_black = 12'h000;
  localparam logic [11:0] rgb_dot   = 12'h941;  // Brown
  localparam logic [11:0] rgb_pac   = 12'hFF0;  // Yellow
  localparam logic [11:0] rgb_wall  = 12'h00F;  // Blue

  logic               pclk;
  logic               rst_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [11:0]        paddr;
  logic [31:0]        pwdata;
  pac_pkg::apb_word_t prdata;
  logic               pready;
  logic               pslverr;
  coord_t             h;
  coord_t             v;
  logic               hs;
  logic               vs;
  logic [3:0]         r;
  logic [3:0]         g;
  logic [3:0]         b;

  // Reference model state
  logic [1:0]  m_cells [pac_pkg::tile_count];  // {wall, dot}
  int          m_h;
  int          m_v;
  int          m_x;
  int          m_y;
  int          m_rem;
  logic [1:0]  m_dir;
  logic [11:0] exp_rgb;                        // Registered outputs lag by one cycle
  logic        exp_hs;
  logic        exp_vs;
  coord_t      exp_h;
  coord_t      exp_v;
  int          seed;
  int          errors;
  int          cycles;

  pacman_top i_dut (
    .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .h, .v, .hs, .vs, .r, .g, .b
  );

  always #20 pclk = ~pclk;  // 25 MHz pixel clock

  // ------------------------------------------------------------------
  // Compare tasks
  task automatic stop_run;
    errors = errors + 1;
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first mismatch");
  endtask

  task automatic check_rgb(input string name, input logic [11:0] got, input logic [11:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      stop_run;
    end
  endtask

  task automatic check_word(input string name, input pac_pkg::apb_word_t got,
                            input pac_pkg::apb_word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      stop_run;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      stop_run;
    end
  endtask

  task automatic check_coord(input string name, input coord_t got, input coord_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      stop_run;
    end
  endtask

  // ------------------------------------------------------------------
  // Reference model
  function automatic int heading_x(input logic [1:0] d);
    return (d == pac_pkg::dir_right) ? 1 : (d == pac_pkg::dir_left) ? -1 : 0;
  endfunction

  function automatic int heading_y(input logic [1:0] d);
    return (d == pac_pkg::dir_down) ? 1 : (d == pac_pkg::dir_up) ? -1 : 0;
  endfunction

  // Off-grid points block like walls
  function automatic logic wall_or_edge(input int x, input int y);
    if (x < 0 || x >= pac_pkg::img_w || y < 0 || y >= pac_pkg::img_h) return 1'b1;
    return m_cells[10'((y / tile_px) * pac_pkg::tiles_x + x / tile_px)][1];
  endfunction

  // Both front corners sit step plus radius ahead and radius to either side
  task automatic front_points(input int step, output int ax, output int ay,
                              output int bx, output int by);
    int dx;
    int dy;
    int reach;
    dx    = heading_x(m_dir);
    dy    = heading_y(m_dir);
    reach = pac_pkg::hit_r + step;
    ax    = m_x + dx * reach + dy * pac_pkg::hit_r;
    bx    = m_x + dx * reach - dy * pac_pkg::hit_r;
    ay    = m_y + dy * reach + dx * pac_pkg::hit_r;
    by    = m_y + dy * reach - dx * pac_pkg::hit_r;
  endtask

  task automatic step_frame;
    int sum;
    int step;
    int ax;
    int ay;
    int bx;
    int by;
    sum  = m_rem + pac_pkg::speed_num;
    step = 0;
    while (sum >= pac_pkg::speed_den) begin  // One pixel per whole 99
      sum  = sum - pac_pkg::speed_den;
      step = step + 1;
    end
    m_rem = sum;
    front_points(step, ax, ay, bx, by);
    if (!wall_or_edge(ax, ay) && !wall_or_edge(bx, by)) begin
      m_x = m_x + heading_x(m_dir) * step;
      m_y = m_y + heading_y(m_dir) * step;
    end
  endtask

  function automatic logic [11:0] expected_pixel(input int x, input int y);
    int lx;
    int ly;
    int t;
    if (x >= pac_pkg::h_vis || y >= pac_pkg::v_vis) return rgb_black;  // Blanked
    if (x < pac_pkg::img_x0 || x >= pac_pkg::img_x0 + pac_pkg::img_w ||
        y < pac_pkg::img_y0 || y >= pac_pkg::img_y0 + pac_pkg::img_h) return rgb_black;
    lx = x - pac_pkg::img_x0;
    ly = y - pac_pkg::img_y0;
    if (lx >= m_x - pac_pkg::hit_r && lx <= m_x + pac_pkg::hit_r &&
        ly >= m_y - pac_pkg::hit_r && ly <= m_y + pac_pkg::hit_r) return rgb_pac;
    t = (ly / tile_px) * pac_pkg::tiles_x + lx / tile_px;
    if (m_cells[10'(t)][0] && (lx % tile_px == 3 || lx % tile_px == 4) &&
        (ly % tile_px == 3 || ly % tile_px == 4)) return rgb_dot;
    if (m_cells[10'(t)][1]) return rgb_wall;
    return rgb_black;
  endfunction

  // Map hole and status writes answer with an error
  function automatic logic is_slave_error(input logic [11:0] addr, input logic write);
    int word;
    word = int'(addr[11:2]);
    return (word >= pac_pkg::tile_count && word < int'(pac_pkg::status_addr)) ||
           (word == int'(pac_pkg::status_addr) && write);
  endfunction

  function automatic pac_pkg::apb_word_t expected_read(input logic [9:0] word);
    pac_pkg::apb_word_t w;
    w = '0;
    if (int'(word) < pac_pkg::tile_count) begin
      w.tile.wall = m_cells[word][1];
      w.tile.dot  = m_cells[word][0];
    end else if (word == pac_pkg::ctrl_addr) begin
      w.ctrl.dir = m_dir;
    end else if (word == pac_pkg::status_addr) begin
      w.status.x = 9'(m_x);
      w.status.y = 9'(m_y);
    end
    return w;
  endfunction

  task automatic track_write;
    pac_pkg::apb_word_t wd;
    int word;
    wd   = pwdata;
    word = int'(paddr[11:2]);
    if (psel && penable && pwrite && !is_slave_error(paddr, pwrite)) begin
      if (word < pac_pkg::tile_count) begin
        m_cells[10'(word)] = {wd.tile.wall, wd.tile.dot};
      end else if (word == int'(pac_pkg::ctrl_addr)) begin
        m_dir = wd.ctrl.dir;
      end
    end
  endtask

  task automatic clear_model;
    for (int i = 0; i < pac_pkg::tile_count; i++) begin
      m_cells[10'(i)] = 2'b00;
    end
    m_h     = 0;
    m_v     = 0;
    m_x     = pac_pkg::start_x;
    m_y     = pac_pkg::start_y;
    m_rem   = 0;
    m_dir   = pac_pkg::start_dir;
    exp_rgb = rgb_black;
    exp_hs  = 1'b1;                            // Syncs idle high
    exp_vs  = 1'b1;
    exp_h   = '0;
    exp_v   = '0;
  endtask

  // ------------------------------------------------------------------
  // Cycle monitor sampling at the falling edge
  always @(negedge pclk) begin
    if (!rst_n) begin
      clear_model;
    end else begin
      check_rgb("rgb", {r, g, b}, exp_rgb);
      check_flag("hs", hs, exp_hs);
      check_flag("vs", vs, exp_vs);
      check_coord("h", h, exp_h);
      check_coord("v", v, exp_v);
      check_flag("pready", pready, 1'b1);
      check_flag("pslverr", pslverr, psel && penable && is_slave_error(paddr, pwrite));
      if (psel && penable && !pwrite && !is_slave_error(paddr, pwrite)) begin
        check_word("prdata", prdata, expected_read(paddr[11:2]));
      end
      // What the output register takes at the next edge
      exp_rgb = expected_pixel(m_h, m_v);
      exp_hs  = !(m_h >= hs_first && m_h <= hs_last);
      exp_vs  = !(m_v >= vs_first && m_v <= vs_last);
      exp_h   = coord_t'(m_h);
      exp_v   = coord_t'(m_v);
      if (m_h == 0 && m_v == 0) begin
        step_frame;                            // Frame tick
      end
      track_write;
      if (m_h == pac_pkg::h_tot - 1) begin
        m_h = 0;
        m_v = (m_v == pac_pkg::v_tot - 1) ? 0 : m_v + 1;
      end else begin
        m_h = m_h + 1;
      end
    end
  end

  always @(posedge pclk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: no result after %0d cycles", cycles);
      $display(">>> FAIL");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // ------------------------------------------------------------------
  // APB tasks start 2 ns after a rising edge
  task automatic write_word(input logic [9:0] word, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = {word, 2'b00};
    pwdata  = data;
    @(posedge pclk);
    #2 penable = 1'b1;                         // Access phase
    @(posedge pclk);
    #2 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_word(input logic [9:0] word, output pac_pkg::apb_word_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = {word, 2'b00};
    @(posedge pclk);
    #2 penable = 1'b1;
    @(negedge pclk);
    data = prdata;
    @(posedge pclk);
    #2 psel = 1'b0;
    penable = 1'b0;
  endtask

  // Start of vertical blanking as seen on the outputs
  task automatic wait_vblank;
    @(negedge pclk);
    while (!(v == coord_t'(pac_pkg::v_vis) && h == '0)) begin
      @(negedge pclk);
    end
    @(posedge pclk);
    #2;
  endtask

  task automatic load_map;
    int   tx;
    int   ty;
    int   rnd;
    logic wall;
    logic dot;
    for (int t = 0; t < pac_pkg::tile_count; t++) begin
      tx   = t % pac_pkg::tiles_x;
      ty   = t / pac_pkg::tiles_x;
      rnd  = $random(seed);
      wall = (rnd[1:0] == 2'b00);              // About one inner tile in four
      dot  = rnd[2];
      if (tx == 0 || tx == pac_pkg::tiles_x - 1 || ty == 0 || ty == pac_pkg::tiles_y - 1) begin
        wall = 1'b1;                           // Border
      end
      if (tx >= pac_pkg::start_x / tile_px - 1 && tx <= pac_pkg::start_x / tile_px + 1 &&
          ty >= pac_pkg::start_y / tile_px - 1 && ty <= pac_pkg::start_y / tile_px + 1) begin
        wall = 1'b0;                           // Room around the start tile
      end
      write_word(10'(t), {30'd0, wall, dot});
    end
  endtask

  task automatic place_wall(input int x, input int y);
    if (x >= 0 && x < pac_pkg::img_w && y >= 0 && y < pac_pkg::img_h) begin
      write_word(10'((y / tile_px) * pac_pkg::tiles_x + x / tile_px), 32'h0000_0002);
    end
  endtask

  // Walls under both front corners for either step size
  task automatic block_ahead;
    int ax;
    int ay;
    int bx;
    int by;
    for (int s = 1; s <= 2; s++) begin
      front_points(s, ax, ay, bx, by);
      place_wall(ax, ay);
      place_wall(bx, by);
    end
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  initial begin
    pac_pkg::apb_word_t got;
    pac_pkg::apb_word_t held;
    seed    = 32'h13ee_d806;
    errors  = 0;
    cycles  = 0;
    pclk    = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (8) @(posedge pclk);
    #2 rst_n = 1'b1;

    // Frame 0 shows the empty map and the map loads in its blanking
    wait_vblank;
    load_map;
    read_word(10'd1010, got);                  // Hole between map and registers
    write_word(10'd1010, 32'hFFFF_FFFF);
    write_word(pac_pkg::status_addr, 32'h0003_0003);
    for (int n = 0; n < tile_reads; n++) begin
      read_word(10'($unsigned($random(seed)) % pac_pkg::tile_count), got);
    end

    // Five random headings plus the first move after reset give six moves
    for (int f = 0; f < 5; f++) begin
      if (f > 0) wait_vblank;
      read_word(pac_pkg::status_addr, got);
      write_word(pac_pkg::ctrl_addr, {30'd0, 2'($random(seed))});
      read_word(pac_pkg::ctrl_addr, got);
    end

    // Wall in front holds the position over two ticks
    wait_vblank;
    read_word(pac_pkg::status_addr, got);
    held = expected_read(pac_pkg::status_addr);
    block_ahead;
    repeat (2) begin
      wait_vblank;
      read_word(pac_pkg::status_addr, got);
      check_word("status", got, held);
    end

    repeat (4) @(posedge pclk);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
design/pac_pkg.sv
design/vga_timing.sv
design/maze_apb_regs.sv
design/pac_motion.sv
design/pixel_render.sv
design/pacman_top.sv
test/tb_pacman.sv

// ==== Makefile ====
# Verilator build and run of the maze display testbench

VERILATOR ?= verilator
TOP       ?= tb_pacman
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
